// ==== hw/vicRasterPkg.sv ====
package vicRasterPkg;

	// ======================================================================
	// Counter and bus widths
	// ======================================================================

	// The X counters span a full line of pixel clocks
	localparam int xWidth = 11;
	// The Y counters span a full frame of lines
	localparam int yWidth = 9;
	// APB data path width
	localparam int dataWidth = 16;
	// Word address into the register file
	localparam int addrWidth = 3;

	// ======================================================================
	// Raster timing constants
	// ======================================================================

	// Pre-raster position where the visible line begins again
	localparam logic [xWidth-1:0] xStart = 11'h14;
	// Line length minus one after reset
	localparam logic [xWidth-1:0] defXMax = 11'd503;
	// Frame height minus one after reset
	localparam logic [yWidth-1:0] defYMax = 9'd311;

	// Bit position of the enable in ctrl and of the flag in status
	localparam int irqBit = 0;

	// Register map of the APB port
	// Address 7 is left undecoded and answers with an error
	typedef enum logic [addrWidth-1:0] {
		regXMax    = 3'd0,
		regYMax    = 3'd1,
		regIrqLine = 3'd2,
		regCtrl    = 3'd3,
		regStatus  = 3'd4,
		regRasterY = 3'd5,
		regNextY   = 3'd6
	} regAddrE;

endpackage

// ==== hw/vicRasterCfgIf.sv ====
`timescale 1ns/1ps

interface vicRasterCfgIf import vicRasterPkg::*; ();

	// Configuration written by the CPU
	logic [xWidth-1:0] rasterXMax;
	logic [yWidth-1:0] rasterYMax;
	logic [yWidth-1:0] irqLine;
	logic irqEnable;
	// Single cycle pulse from a status write of one
	logic irqClear;

	// Status coming back from the raster blocks
	logic irqStatus;
	logic [yWidth-1:0] rasterY;
	logic [yWidth-1:0] nextRasterY;

	// Register block drives all configuration and reads back status
	modport regs (
		output rasterXMax, rasterYMax, irqLine, irqEnable, irqClear,
		input irqStatus, rasterY, nextRasterY
	);

	// Counter block needs only the limits
	modport counter (input rasterXMax, rasterYMax, output rasterY, nextRasterY);

	// Interrupt block owns the sticky status flag
	modport irq (input irqLine, irqEnable, irqClear, output irqStatus);

endinterface

// ==== hw/vicRasterXY.sv ====
`timescale 1ns/1ps

module vicRasterXY import vicRasterPkg::*; (
	input  logic rst,
	input  logic clk8,
	vicRasterCfgIf.counter cfg,
	output logic [xWidth-1:0] preRasterX,
	output logic [xWidth-1:0] rasterX,
	output logic [yWidth-1:0] preRasterY
);

	// End of the pre-raster line
	logic lineWrap;
	// Pre-raster position where the visible line starts
	logic lineStart;

	assign lineWrap = (preRasterX == cfg.rasterXMax);
	assign lineStart = (preRasterX == xStart);

	// ======================================================================
	// Pre-raster counters
	// ======================================================================

	// Free running pixel position that wraps at the programmed line length
	always_ff @(posedge clk8) begin
		if (rst) begin
			preRasterX <= '0;
		end else if (lineWrap) begin
			preRasterX <= '0;
		end else begin
			preRasterX <= preRasterX + xWidth'(1);
		end
	end

	// Line count steps once per wrap of the X counter
	// A new maximum takes effect at the next comparison
	always_ff @(posedge clk8) begin
		if (rst) begin
			preRasterY <= '0;
		end else if (lineWrap) begin
			if (preRasterY == cfg.rasterYMax) begin
				preRasterY <= '0;
			end else begin
				preRasterY <= preRasterY + yWidth'(1);
			end
		end
	end

	// ======================================================================
	// Visible raster counters
	// ======================================================================

	// Visible X is the pre-raster position shifted by xStart
	always_ff @(posedge clk8) begin
		if (rst) begin
			rasterX <= '0;
		end else if (lineStart) begin
			rasterX <= '0;
		end else begin
			rasterX <= rasterX + xWidth'(1);
		end
	end

	// The visible line is latched at the same point the X count restarts
	always_ff @(posedge clk8) begin
		if (rst) begin
			cfg.rasterY <= '0;
		end else if (lineStart) begin
			cfg.rasterY <= preRasterY;
		end
	end

	// Prediction of the following line, one cycle into the new line
	// It does not fold back at the frame end
	always_ff @(posedge clk8) begin
		if (rst) begin
			cfg.nextRasterY <= '0;
		end else if (rasterX == '0) begin
			cfg.nextRasterY <= cfg.rasterY + yWidth'(1);
		end
	end

endmodule

// ==== hw/vicRasterIrq.sv ====
`timescale 1ns/1ps

module vicRasterIrq import vicRasterPkg::*; (
	input  logic rst,
	input  logic clk8,
	input  logic [xWidth-1:0] preRasterX,
	input  logic [yWidth-1:0] preRasterY,
	vicRasterCfgIf.irq cfg,
	output logic irq
);

	// Programmed line is about to become the visible line
	logic lineMatch;

	// ======================================================================
	// Raster compare
	// ======================================================================

	// Uses the same pre-raster condition that loads rasterY
	// So the status flag sets on the very edge where rasterY takes irqLine
	always_comb begin
		lineMatch = 1'b0;
		if (preRasterX == xStart) begin
			lineMatch = (preRasterY == cfg.irqLine);
		end
	end

	// ======================================================================
	// Sticky status and output
	// ======================================================================

	// Status holds until the CPU clears it
	// A match in the same cycle as a clear keeps the flag set
	always_ff @(posedge clk8) begin
		if (rst) begin
			cfg.irqStatus <= 1'b0;
		end else if (lineMatch) begin
			cfg.irqStatus <= 1'b1;
		end else if (cfg.irqClear) begin
			cfg.irqStatus <= 1'b0;
		end
	end

	// Registered request line
	// Follows status one cycle late and only while the enable is set
	always_ff @(posedge clk8) begin
		if (rst) begin
			irq <= 1'b0;
		end else begin
			irq <= cfg.irqStatus & cfg.irqEnable;
		end
	end

endmodule

// ==== hw/vicRegs.sv ====
`timescale 1ns/1ps

module vicRegs import vicRasterPkg::*; (
	input  logic rst,
	input  logic clk8,
	input  logic pSel,
	input  logic pEnable,
	input  logic pWrite,
	input  logic [addrWidth-1:0] pAddr,
	input  logic [dataWidth-1:0] pWData,
	output logic [dataWidth-1:0] pRData,
	output logic pSlvErr,
	vicRasterCfgIf.regs cfg
);

	// Decoded register address
	regAddrE addrE;
	// Second cycle of an APB transfer
	logic access;
	// Write that completes at the end of this cycle
	logic wrEn;
	// Address falls inside the decoded map
	logic addrValid;

	assign addrE = regAddrE'(pAddr);
	assign access = pSel & pEnable;
	assign wrEn = access & pWrite & addrValid;

	// ======================================================================
	// Address decode and error response
	// ======================================================================

	always_comb begin
		case (addrE)
			regXMax, regYMax, regIrqLine, regCtrl,
			regStatus, regRasterY, regNextY: addrValid = 1'b1;
			default: addrValid = 1'b0;
		endcase
	end

	// The error flag is only meaningful during the access cycle
	assign pSlvErr = access & ~addrValid;

	// Writing one to the status flag clears it at the end of this access
	assign cfg.irqClear = wrEn & (addrE == regStatus) & pWData[irqBit];

	// ======================================================================
	// Register file
	// ======================================================================

	// Write data is cut down to the width of each field
	// Read-only addresses ignore the write apart from the status clear above
	always_ff @(posedge clk8) begin
		if (rst) begin
			cfg.rasterXMax <= defXMax;
			cfg.rasterYMax <= defYMax;
			cfg.irqLine <= '0;
			cfg.irqEnable <= 1'b0;
		end else if (wrEn) begin
			case (addrE)
				regXMax: cfg.rasterXMax <= pWData[xWidth-1:0];
				regYMax: cfg.rasterYMax <= pWData[yWidth-1:0];
				regIrqLine: cfg.irqLine <= pWData[yWidth-1:0];
				regCtrl: cfg.irqEnable <= pWData[irqBit];
				default: ;
			endcase
		end
	end

	// ======================================================================
	// Read multiplexer
	// ======================================================================

	// Purely combinational so data is valid in the access cycle
	// Unused upper bits read as zero
	always_comb begin
		pRData = '0;
		case (addrE)
			regXMax: pRData[xWidth-1:0] = cfg.rasterXMax;
			regYMax: pRData[yWidth-1:0] = cfg.rasterYMax;
			regIrqLine: pRData[yWidth-1:0] = cfg.irqLine;
			regCtrl: pRData[irqBit] = cfg.irqEnable;
			regStatus: pRData[irqBit] = cfg.irqStatus;
			regRasterY: pRData[yWidth-1:0] = cfg.rasterY;
			regNextY: pRData[yWidth-1:0] = cfg.nextRasterY;
			default: pRData = '0;
		endcase
	end

endmodule

// ==== hw/vicRaster.sv ====
`timescale 1ns/1ps

module vicRaster import vicRasterPkg::*; (
	input  logic rst,
	input  logic clk8,
	input  logic pSel,
	input  logic pEnable,
	input  logic pWrite,
	input  logic [addrWidth-1:0] pAddr,
	input  logic [dataWidth-1:0] pWData,
	output logic [dataWidth-1:0] pRData,
	output logic pSlvErr,
	output logic irq,
	output logic [xWidth-1:0] rasterX,
	output logic [yWidth-1:0] rasterY
);

	// Pre-raster position shared by the counter and the compare logic
	logic [xWidth-1:0] preRasterX;
	logic [yWidth-1:0] preRasterY;

	// Configuration and status bundle between the three blocks
	vicRasterCfgIf cfg ();

	// ======================================================================
	// Block instances
	// ======================================================================

	// CPU side register file
	vicRegs uRegs (
		.rst(rst),
		.clk8(clk8),
		.pSel(pSel),
		.pEnable(pEnable),
		.pWrite(pWrite),
		.pAddr(pAddr),
		.pWData(pWData),
		.pRData(pRData),
		.pSlvErr(pSlvErr),
		.cfg(cfg.regs)
	);

	// Beam position counters
	vicRasterXY uXY (
		.rst(rst),
		.clk8(clk8),
		.cfg(cfg.counter),
		.preRasterX(preRasterX),
		.rasterX(rasterX),
		.preRasterY(preRasterY)
	);

	// Raster line interrupt
	vicRasterIrq uIrq (
		.rst(rst),
		.clk8(clk8),
		.preRasterX(preRasterX),
		.preRasterY(preRasterY),
		.cfg(cfg.irq),
		.irq(irq)
	);

	// Visible line is also brought out for the pixel pipeline
	assign rasterY = cfg.rasterY;

endmodule

// ==== sim/vicRaster_props.sv ====
`timescale 1ns/1ps

module vicRaster_props import vicRasterPkg::*; (
	input logic rst,
	input logic clk8,
	input logic pSel,
	input logic pEnable,
	input logic pWrite,
	input logic [addrWidth-1:0] pAddr,
	input logic [dataWidth-1:0] pWData,
	input logic pSlvErr,
	input logic irq
);

	// Interrupt enable as the CPU last wrote it over APB
	logic ctrlEnable;

	always_ff @(posedge clk8) begin
		if (rst) begin
			ctrlEnable <= 1'b0;
		end else if (pSel && pEnable && pWrite && (pAddr == regCtrl)) begin
			ctrlEnable <= pWData[irqBit];
		end
	end

	// Every access cycle follows the setup cycle of the same transfer
	apbSetupFirst: assert property (@(posedge clk8) disable iff (rst)
		pEnable |-> pSel && $past(pSel && !pEnable))
		else $error("pEnable high without a preceding setup cycle");

	// The request line is registered and lags the written enable by one cycle
	irqGated: assert property (@(posedge clk8) disable iff (rst)
		irq |-> $past(ctrlEnable))
		else $error("irq high while the interrupt enable was low");

	// Only the undecoded address answers with an error
	errOnlyUndecoded: assert property (@(posedge clk8) disable iff (rst)
		pSlvErr |-> (pAddr == 3'd7))
		else $error("pSlvErr high for a decoded address");

endmodule

bind vicRaster vicRaster_props uProps (.rst(rst), .clk8(clk8), .pSel(pSel), .pEnable(pEnable),
	.pWrite(pWrite), .pAddr(pAddr), .pWData(pWData), .pSlvErr(pSlvErr), .irq(irq));

// ==== sim/tbVicRaster.sv ====
`timescale 1ns/1ps

module tbVicRaster import vicRasterPkg::*; ();

	// Longest wait in clock cycles
	// It covers many frames of the reduced raster used by the stimulus
	localparam int waitLimit = 50000;

	logic rst, clk8, pSel, pEnable, pWrite, pSlvErr, irq, rdErr;
	logic [addrWidth-1:0] pAddr, stAddr;
	logic [dataWidth-1:0] pWData, pRData, rdData, stData, stExp;
	logic [xWidth-1:0] rasterX, modelXMax, expX;
	logic [yWidth-1:0] rasterY, modelYMax, modelLine, expNext;
	int fd, code, testNum, passCount, failCount, errCount;
	string op, skipped;

	vicRaster UUT (.*);

	initial begin
		clk8 = 1'b0;
		forever #10 clk8 = ~clk8;
	end

	// Line that follows under the frame height last written
	function automatic logic [yWidth-1:0] nextLine(input logic [yWidth-1:0] line);
		return (line == modelYMax) ? '0 : line + 1'b1;
	endfunction

	// Compares one value and reports a mismatch in hex
	task automatic checkHex(input string name, input logic [15:0] got, input logic [15:0] want);
		if (got !== want) begin
			$display("Error: %s is %h, expected %h", name, got, want);
			errCount++;
		end
	endtask

	// ======================================================================
	// APB transfers
	// ======================================================================

	// Setup cycle then access cycle
	// The response is taken in the access cycle
	task automatic busCycle(input logic wr, input logic [addrWidth-1:0] addr,
			input logic [dataWidth-1:0] data);
		@(posedge clk8);
		pSel <= 1'b1;
		pEnable <= 1'b0;
		pWrite <= wr;
		pAddr <= addr;
		pWData <= data;
		@(posedge clk8);
		pEnable <= 1'b1;
		@(negedge clk8);
		rdData = pRData;
		rdErr = pSlvErr;
		@(posedge clk8);
		pSel <= 1'b0;
		pEnable <= 1'b0;
		// Only the undecoded address answers with an error
		checkHex("pSlvErr", rdErr, addr == 3'd7);
	endtask

	// A new maximum also goes into the raster model
	task automatic writeReg(input logic [addrWidth-1:0] addr, input logic [dataWidth-1:0] data);
		busCycle(1'b1, addr, data);
		if (addr == regXMax)
			modelXMax = data[xWidth-1:0];
		if (addr == regYMax)
			modelYMax = data[yWidth-1:0];
	endtask

	task automatic readReg(input logic [addrWidth-1:0] addr);
		busCycle(1'b0, addr, '0);
	endtask

	// ======================================================================
	// Waits on the raster
	// ======================================================================

	// Waits until rasterY steps onto a line
	// irq may be required to stay low meanwhile
	task automatic waitLine(input logic [yWidth-1:0] line, input logic watchIrq);
		logic [yWidth-1:0] prevY;
		logic arrived;
		int cycles;
		@(negedge clk8);
		prevY = rasterY;
		cycles = 0;
		do begin
			@(negedge clk8);
			cycles++;
			arrived = (rasterY == line) && (prevY != line);
			if (watchIrq && irq) begin
				$display("irq went high before line %0d started", line);
				errCount++;
				watchIrq = 1'b0;
			end
			prevY = rasterY;
		end while (!arrived && cycles < waitLimit);
		if (!arrived) begin
			$display("Timed out waiting for line %0d", line);
			errCount++;
		end
		modelLine = line;
	endtask

	task automatic waitIrq(input logic level);
		int cycles;
		cycles = 0;
		@(negedge clk8);
		while (irq !== level && cycles < waitLimit) begin
			@(negedge clk8);
			cycles++;
		end
		if (irq !== level) begin
			$display("Timed out waiting for irq to become %0d", level);
			errCount++;
		end
	endtask

	// Follows rasterX and rasterY cycle by cycle from the start of line 0
	// The visible X restarts once per line so each line is xMax+1 cycles
	task automatic countFrames(input int frames);
		int total;
		waitLine('0, 1'b0);
		expX = '0;
		total = frames * (modelYMax + 1) * (modelXMax + 1);
		for (int i = 0; i < total && errCount == 0; i++) begin
			if (i > 0) begin
				@(negedge clk8);
				if (expX == modelXMax) begin
					expX = '0;
					modelLine = nextLine(modelLine);
				end else begin
					expX = expX + 1'b1;
				end
			end
			checkHex("rasterX", rasterX, expX);
			checkHex("rasterY", rasterY, modelLine);
		end
	endtask

	// ======================================================================
	// Stimulus file sequencer
	// ======================================================================

	initial begin
		rst = 1'b1;
		pSel = 1'b0;
		pEnable = 1'b0;
		pWrite = 1'b0;
		pAddr = '0;
		pWData = '0;
		testNum = 0;
		passCount = 0;
		failCount = 0;
		modelXMax = defXMax;
		modelYMax = defYMax;
		modelLine = '0;
		fd = $fopen("sim/stimVicRaster.txt", "r");
		if (fd == 0) begin
			$display("The stimulus file could not be opened");
			failCount++;
		end
		repeat (5) @(posedge clk8);
		rst <= 1'b0;
		while (fd != 0 && $fscanf(fd, "%s", op) == 1) begin
			if (op == "#") begin
				code = $fgets(skipped, fd);
			end else begin
				code = $fscanf(fd, "%h %h %h", stAddr, stData, stExp);
				errCount = 0;
				testNum++;
				if (code != 3) begin
					$display("The stimulus line for operation %s is incomplete", op);
					errCount++;
				end else if (op == "W") begin
					writeReg(stAddr, stData);
				end else if (op == "R") begin
					readReg(stAddr);
					// The data column masks the bits under test
					checkHex("pRData", rdData & stData, stExp);
				end else if (op == "I") begin
					waitIrq(stExp[0]);
					if (stAddr[0])
						checkHex("rasterY", rasterY, stData);
				end else if (op == "L") begin
					waitLine(stData[yWidth-1:0], stAddr[0]);
					// irq lags the status flag by one cycle
					repeat (2) @(negedge clk8);
					checkHex("irq", irq, stExp);
				end else if (op == "C") begin
					countFrames(stData);
				end else if (op == "N") begin
					for (int i = 0; i < stData; i++) begin
						waitLine(nextLine(modelLine), 1'b0);
						readReg(regNextY);
						expNext = modelLine + 1'b1;
						checkHex("regNextY", rdData, expNext);
					end
				end else begin
					$display("Unknown operation %s in the stimulus file", op);
					errCount++;
				end
				if (errCount == 0)
					passCount++;
				else
					failCount++;
				$display("Test %0d %s %h %h %h %s", testNum, op, stAddr, stData, stExp,
					(errCount == 0) ? "passed" : "failed");
			end
		end
		$display("Tests run %0d, passed %0d, failed %0d", testNum, passCount, failCount);
		if (failCount == 0 && testNum > 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== sim/stimVicRaster.txt ====
# op addr data exp in hex: W writes data, R reads and compares read data masked by data with exp
# I waits for irq equal exp, L waits for line data then checks irq, C counts data frames, N checks data lines
R 4 ffff 0000
R 0 ffff 01f7
R 1 ffff 0137
R 2 ffff 0000
R 3 ffff 0000
W 0 f83f 0
R 0 ffff 003f
W 1 fe0f 0
R 1 ffff 000f
W 2 fe09 0
R 2 ffff 0009
W 3 fffe 0
R 3 ffff 0000
C 0 2 0
N 0 12 0
W 4 1 0
W 3 1 0
I 1 9 1
R 4 ffff 0001
W 4 1 0
I 0 0 0
L 1 9 1
W 4 1 0
W 3 0 0
L 1 9 0
R 4 ffff 0001
W 7 ffff 0
R 7 ffff 0000
R 0 ffff 003f
R 1 ffff 000f
R 2 ffff 0009
R 3 ffff 0000
R 4 ffff 0001

// ==== vicRaster.f ====
hw/vicRasterPkg.sv
hw/vicRasterCfgIf.sv
hw/vicRasterXY.sv
hw/vicRasterIrq.sv
hw/vicRegs.sv
hw/vicRaster.sv
sim/vicRaster_props.sv
sim/tbVicRaster.sv

// ==== Bender.yml ====
package:
  name: vic_raster

sources:
  - files:
      - hw/vicRasterPkg.sv
      - hw/vicRasterCfgIf.sv
      - hw/vicRasterXY.sv
      - hw/vicRasterIrq.sv
      - hw/vicRegs.sv
      - hw/vicRaster.sv
  - target: simulation
    files:
      - sim/vicRaster_props.sv
      - sim/tbVicRaster.sv
